// File: fpu_pkg.sv
package fpu_pkg;

   // funct7 op codes, same values as the integer decoder
   localparam logic [6:0] op_add = 7'b0100000;
   localparam logic [6:0] op_sub = 7'b0100100;
   localparam logic [6:0] op_mul = 7'b0000010;

   // only rtz is decoded, every other frm rounds nearest even
   localparam logic [2:0] frm_rtz = 3'b001;

   // flag word bit positions
   localparam int flag_nv = 4;   // invalid
   localparam int flag_dz = 3;   // div by zero, never set
   localparam int flag_of = 2;   // overflow
   localparam int flag_uf = 1;   // underflow
   localparam int flag_nx = 0;   // inexact

   localparam logic [31:0] canon_nan = 32'h7fc00000;

   // add/sub view of the stage 1 word
   // fracs are 1.23 significands followed by guard, round, sticky
   typedef struct packed {
      logic [1:0]  pad;
      logic        big_sign;
      logic [26:0] big_frac;     // larger magnitude, unshifted
      logic        small_sign;
      logic [26:0] small_frac;   // aligned to exp_max, lsb is sticky
      logic [7:0]  exp_max;
   } s1_addsub_t;

   // mul view, full 2.46 product kept for rounding
   typedef struct packed {
      logic        pad;
      logic        sign;
      logic [7:0]  exp_a;
      logic [7:0]  exp_b;
      logic [47:0] prod;
   } s1_mul_t;

   // one 66 bit word, read by stage 2 according to funct7
   typedef union packed {
      s1_addsub_t addsub;
      s1_mul_t    mul;
   } s1_word_u;

endpackage

// File: fpu_align.sv
`timescale 1ns/1ps

module fpu_align (
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  logic        sub,
   output logic        big_sign,
   output logic [26:0] big_frac,
   output logic        small_sign,
   output logic [26:0] small_frac,
   output logic [7:0]  exp_max
);

   logic        b_sign;
   logic [23:0] sig_a;
   logic [23:0] sig_b;
   logic        a_big;
   logic [7:0]  exp_min;
   logic [7:0]  exp_diff;
   logic [4:0]  sh;
   logic [26:0] sm_frac;
   logic [53:0] sm_wide;   // shifted value on top, lost bits below

   assign b_sign = b[31] ^ sub;   // a - b handled as a + (-b)

   // hidden one only for normals, subnormals read as zero
   assign sig_a = (a[30:23] != 8'd0) ? {1'b1, a[22:0]} : 24'd0;
   assign sig_b = (b[30:23] != 8'd0) ? {1'b1, b[22:0]} : 24'd0;

   // magnitude order, exponent first then significand
   assign a_big = {a[30:23], sig_a} >= {b[30:23], sig_b};

   assign big_sign   = a_big ? a[31] : b_sign;
   assign small_sign = a_big ? b_sign : a[31];
   assign big_frac   = a_big ? {sig_a, 3'b000} : {sig_b, 3'b000};
   assign sm_frac    = a_big ? {sig_b, 3'b000} : {sig_a, 3'b000};
   assign exp_max    = a_big ? a[30:23] : b[30:23];
   assign exp_min    = a_big ? b[30:23] : a[30:23];

   assign exp_diff = exp_max - exp_min;   // never negative after ordering
   // past 27 everything is in the sticky anyway
   assign sh = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];

   assign sm_wide = {sm_frac, 27'd0} >> sh;

   // fold everything shifted out into bit 0
   assign small_frac = {sm_wide[53:28], sm_wide[27] | (|sm_wide[26:0])};

endmodule

// File: fpu_stage1.sv
`timescale 1ns/1ps

module fpu_stage1 import fpu_pkg::*; (
   input  logic        clk,
   input  logic        nrst,
   input  logic        op_valid,
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  logic [6:0]  funct7,
   input  logic [2:0]  frm,
   output logic        s1_valid,
   output s1_word_u    s1_word,
   output logic [6:0]  s1_funct7,
   output logic [2:0]  s1_frm,
   output logic        s1_special,
   output logic [31:0] s1_special_res,
   output logic        s1_nv
);

   logic        is_add, is_sub, is_mul;
   logic        a_nan, a_inf, a_zero;
   logic        b_nan, b_inf, b_zero;
   logic        b_sign_eff;
   logic        mul_sign;
   logic        al_big_sign, al_small_sign;
   logic [26:0] al_big_frac, al_small_frac;
   logic [7:0]  al_exp;
   logic [47:0] prod;
   logic        special, nv;
   logic [31:0] special_res;
   s1_word_u    word;

   assign is_add = funct7 == op_add;
   assign is_sub = funct7 == op_sub;
   assign is_mul = funct7 == op_mul;

   // operand classes, exp 0 counts as zero
   assign a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
   assign a_inf  = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
   assign a_zero = a[30:23] == 8'd0;
   assign b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
   assign b_inf  = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
   assign b_zero = b[30:23] == 8'd0;

   assign b_sign_eff = b[31] ^ is_sub;
   assign mul_sign   = a[31] ^ b[31];

   fpu_align fpu_align_i (
      .a          (a),
      .b          (b),
      .sub        (is_sub),
      .big_sign   (al_big_sign),
      .big_frac   (al_big_frac),
      .small_sign (al_small_sign),
      .small_frac (al_small_frac),
      .exp_max    (al_exp)
   );

   // 24x24 significand product, only used when both are normal
   assign prod = {1'b1, a[22:0]} * {1'b1, b[22:0]};

   always_comb begin
      special     = 1'b1;
      nv          = 1'b0;
      special_res = canon_nan;
      if (!(is_add || is_sub || is_mul)) begin
         nv = 1'b1;   // unknown funct7
      end else if (a_nan || b_nan) begin
         nv = 1'b1;
      end else if (is_mul) begin
         if ((a_zero && b_inf) || (a_inf && b_zero))
            nv = 1'b1;   // 0 * inf
         else if (a_inf || b_inf)
            special_res = {mul_sign, 8'hff, 23'd0};
         else if (a_zero || b_zero)
            special_res = {mul_sign, 31'd0};   // signed zero, exact
         else
            special = 1'b0;
      end else begin
         if (a_inf && b_inf && (a[31] != b_sign_eff))
            nv = 1'b1;   // inf - inf
         else if (a_inf)
            special_res = {a[31], 8'hff, 23'd0};
         else if (b_inf)
            special_res = {b_sign_eff, 8'hff, 23'd0};
         else
            special = 1'b0;   // zeros go through the adder for sign rules
      end
   end

   // fill the view stage 2 will read
   always_comb begin
      word = '0;
      if (is_mul) begin
         word.mul.sign  = mul_sign;
         word.mul.exp_a = a[30:23];
         word.mul.exp_b = b[30:23];
         word.mul.prod  = prod;
      end else begin
         word.addsub.big_sign   = al_big_sign;
         word.addsub.big_frac   = al_big_frac;
         word.addsub.small_sign = al_small_sign;
         word.addsub.small_frac = al_small_frac;
         word.addsub.exp_max    = al_exp;
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst)
         s1_valid <= 1'b0;
      else
         s1_valid <= op_valid;
   end

   // payload, loaded only with a valid op
   always_ff @(posedge clk) begin
      if (op_valid) begin
         s1_word        <= word;
         s1_funct7      <= funct7;
         s1_frm         <= frm;
         s1_special     <= special;
         s1_special_res <= special_res;
         s1_nv          <= nv;
      end
   end

endmodule

// File: fpu_stage2.sv
`timescale 1ns/1ps

module fpu_stage2 import fpu_pkg::*; (
   input  logic        clk,
   input  logic        nrst,
   input  logic        s1_valid,
   input  s1_word_u    s1_word,
   input  logic [6:0]  s1_funct7,
   input  logic [2:0]  s1_frm,
   input  logic        s1_special,
   input  logic [31:0] s1_special_res,
   input  logic        s1_nv,
   output logic        s2_valid,
   output logic        s2_sign,
   output logic [9:0]  s2_exp,
   output logic [47:0] s2_frac,
   output logic [2:0]  s2_frm,
   output logic        s2_special,
   output logic [31:0] s2_special_res,
   output logic        s2_nv
);

   logic        is_mul;
   logic        same_sign;
   logic [27:0] big_ext, small_ext;
   logic [27:0] mag;   // bit 26 is the units bit, bit 27 the carry
   logic        sign;
   logic [9:0]  exp;
   logic [47:0] frac;

   assign is_mul = s1_funct7 == op_mul;

   assign big_ext   = {1'b0, s1_word.addsub.big_frac};
   assign small_ext = {1'b0, s1_word.addsub.small_frac};
   assign same_sign = s1_word.addsub.big_sign == s1_word.addsub.small_sign;

   // big >= small, so the difference never goes negative
   assign mag = same_sign ? big_ext + small_ext : big_ext - small_ext;

   // both results land in a 2.46 frame, bit 46 = units
   always_comb begin
      if (is_mul) begin
         sign = s1_word.mul.sign;
         exp  = {2'b00, s1_word.mul.exp_a} + {2'b00, s1_word.mul.exp_b} - 10'd127;
         frac = s1_word.mul.prod;
      end else begin
         // exact cancel gives +0, -0 + -0 keeps its sign
         sign = (!same_sign && (mag == 28'd0)) ? 1'b0 : s1_word.addsub.big_sign;
         exp  = {2'b00, s1_word.addsub.exp_max};
         frac = {mag, 20'd0};
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst)
         s2_valid <= 1'b0;
      else
         s2_valid <= s1_valid;
   end

   always_ff @(posedge clk) begin
      if (s1_valid) begin
         s2_sign        <= sign;
         s2_exp         <= exp;   // wide, may be out of range here
         s2_frac        <= frac;
         s2_frm         <= s1_frm;
         s2_special     <= s1_special;
         s2_special_res <= s1_special_res;
         s2_nv          <= s1_nv;
      end
   end

endmodule

// File: fpu_round.sv
`timescale 1ns/1ps

module fpu_round import fpu_pkg::*; (
   input  logic        clk,
   input  logic        nrst,
   input  logic        s2_valid,
   input  logic        s2_sign,
   input  logic [9:0]  s2_exp,
   input  logic [47:0] s2_frac,
   input  logic [2:0]  s2_frm,
   input  logic        s2_special,
   input  logic [31:0] s2_special_res,
   input  logic        s2_nv,
   output logic        r_valid,
   output logic [31:0] r_result,
   output logic [flag_nv:0] r_flags
);

   logic [5:0]         lead;     // leading one position
   logic [47:0]        norm;     // leading one moved to bit 47
   logic signed [10:0] exp_n, exp_r;
   logic               g, r, s, lsb;
   logic               rtz, up, inexact;
   logic [24:0]        mant_r;
   logic [31:0]        res;
   logic [flag_nv:0]   fl;

   assign rtz = s2_frm == frm_rtz;

   // last hit wins, so lead ends on the top set bit
   always_comb begin
      lead = 6'd0;
      for (int i = 0; i < 48; i++) begin
         if (s2_frac[i])
            lead = i[5:0];
      end
   end

   assign norm  = s2_frac << (6'd47 - lead);
   assign exp_n = {s2_exp[9], s2_exp} + {5'd0, lead} - 11'd46;

   assign lsb = norm[24];
   assign g   = norm[23];
   assign r   = norm[22];
   assign s   = |norm[21:0];
   assign inexact = g | r | s;

   // nearest even rounds up above half, or on a tie with odd lsb
   assign up     = !rtz && g && (r || s || lsb);
   assign mant_r = {1'b0, norm[47:24]} + {24'd0, up};
   assign exp_r  = exp_n + {10'd0, mant_r[24]};   // mantissa carry out

   always_comb begin
      res = 32'd0;
      fl  = '0;
      fl[flag_dz] = 1'b0;   // no divider in this unit
      if (s2_special) begin
         res = s2_special_res;
         fl[flag_nv] = s2_nv;
      end else if (s2_frac == 48'd0) begin
         res = {s2_sign, 31'd0};   // exact zero
      end else if (exp_r > 11'sd254) begin
         fl[flag_of] = 1'b1;
         fl[flag_nx] = 1'b1;
         res = rtz ? {s2_sign, 8'hfe, 23'h7fffff} : {s2_sign, 8'hff, 23'd0};
      end else if (exp_r < 11'sd1) begin
         fl[flag_uf] = 1'b1;   // flush to signed zero
         fl[flag_nx] = 1'b1;
         res = {s2_sign, 31'd0};
      end else begin
         fl[flag_nx] = inexact;
         // a carry out leaves the low 23 bits zero
         res = {s2_sign, exp_r[7:0], mant_r[22:0]};
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst)
         r_valid <= 1'b0;
      else
         r_valid <= s2_valid;
   end

   always_ff @(posedge clk) begin
      if (s2_valid) begin
         r_result <= res;
         r_flags  <= fl;
      end
   end

endmodule

// File: fpu_result_buf.sv
`timescale 1ns/1ps

module fpu_result_buf import fpu_pkg::*; #(
   parameter int RES_DEPTH   = 4,
   parameter int OUT_CREDITS = 2
) (
   input  logic             clk,
   input  logic             nrst,
   input  logic             r_valid,
   input  logic [31:0]      r_result,
   input  logic [flag_nv:0] r_flags,
   input  logic             res_credit,
   output logic             res_valid,
   output logic [31:0]      result,
   output logic [flag_nv:0] flags,
   output logic             in_credit
);

   localparam int aw = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
   localparam int cw = $clog2(OUT_CREDITS + 1);

   logic [31:0]      res_mem  [RES_DEPTH];
   logic [flag_nv:0] flag_mem [RES_DEPTH];
   logic [aw-1:0]    wr_ptr, rd_ptr;
   logic [aw:0]      count;     // entries held
   logic [cw-1:0]    credits;   // downstream slots we may still fill
   logic             pop;

   // send head when there is one and the consumer has room
   assign pop       = (count != '0) && (credits != '0);
   assign res_valid = pop;
   assign in_credit = pop;   // slot freed, hand it back upstream
   assign result    = res_mem[rd_ptr];
   assign flags     = flag_mem[rd_ptr];

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         credits <= cw'(OUT_CREDITS);
      end else begin
         if (r_valid)
            wr_ptr <= (wr_ptr == aw'(RES_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == aw'(RES_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({r_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
         case ({res_credit, pop})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   // upstream credits keep writes from ever landing on a full buffer
   always_ff @(posedge clk) begin
      if (r_valid) begin
         res_mem[wr_ptr]  <= r_result;
         flag_mem[wr_ptr] <= r_flags;
      end
   end

endmodule

// File: fpu_top.sv
`timescale 1ns/1ps

module fpu_top import fpu_pkg::*; #(
   parameter int RES_DEPTH   = 4,   // upstream credits, buffer slots
   parameter int OUT_CREDITS = 2    // consumer slots at reset
) (
   input  logic             clk,
   input  logic             nrst,
   input  logic             op_valid,
   input  logic [31:0]      a,
   input  logic [31:0]      b,
   input  logic [6:0]       funct7,
   input  logic [2:0]       frm,
   input  logic             res_credit,
   output logic             res_valid,
   output logic [31:0]      result,
   output logic [flag_nv:0] flags,
   output logic             in_credit
);

   // stage 1 -> stage 2
   logic             s1_valid, s1_special, s1_nv;
   s1_word_u         s1_word;
   logic [6:0]       s1_funct7;
   logic [2:0]       s1_frm;
   logic [31:0]      s1_special_res;
   // stage 2 -> round
   logic             s2_valid, s2_sign, s2_special, s2_nv;
   logic [9:0]       s2_exp;
   logic [47:0]      s2_frac;
   logic [2:0]       s2_frm;
   logic [31:0]      s2_special_res;
   // round -> buffer
   logic             r_valid;
   logic [31:0]      r_result;
   logic [flag_nv:0] r_flags;

   fpu_stage1 fpu_stage1_i (.*);   // classify, align, multiply

   fpu_stage2 fpu_stage2_i (.*);   // add or exponent sum

   fpu_round fpu_round_i (.*);     // normalize, round, flags

   fpu_result_buf #(
      .RES_DEPTH   (RES_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) fpu_result_buf_i (.*);

endmodule

// File: fpu_tb_vectors.svh
`ifndef FPU_TB_VECTORS_SVH
`define FPU_TB_VECTORS_SVH

// columns: a, b, funct7, frm, expected result, expected flags
// flags run nv dz of uf nx from bit 4 down
localparam int n_vec = 39;

localparam logic [110:0] vec_tab [n_vec] = '{
   // exact add and sub
   {32'h3f800000, 32'h3f800000, op_add, 3'd0, 32'h40000000, 5'h00},   // 1 + 1
   {32'h3fc00000, 32'hbf000000, op_add, 3'd0, 32'h3f800000, 5'h00},   // 1.5 + -0.5
   {32'h40400000, 32'h3f800000, op_sub, 3'd0, 32'h40000000, 5'h00},   // 3 - 1
   {32'h3f800000, 32'h34000000, op_add, 3'd0, 32'h3f800001, 5'h00},   // 1 + 2^-23
   {32'h3fc00000, 32'h3fc00000, op_sub, 3'd0, 32'h00000000, 5'h00},   // cancel to +0
   {32'h3fc00000, 32'hbfc00000, op_add, 3'd1, 32'h00000000, 5'h00},   // +0 under rtz too
   {32'h80000000, 32'h80000000, op_add, 3'd0, 32'h80000000, 5'h00},   // -0 + -0
   {32'h00400000, 32'h3f800000, op_add, 3'd0, 32'h3f800000, 5'h00},   // subnormal is 0
   // rounding, each pair rne then rtz
   {32'h3f800001, 32'h33800000, op_add, 3'd0, 32'h3f800002, 5'h01},   // tie, odd lsb
   {32'h3f800001, 32'h33800000, op_add, 3'd1, 32'h3f800001, 5'h01},
   {32'h3f800000, 32'h33820000, op_add, 3'd0, 32'h3f800001, 5'h01},   // above half
   {32'h3f800000, 32'h33820000, op_add, 3'd1, 32'h3f800000, 5'h01},
   {32'h3f800000, 32'h33000000, op_add, 3'd0, 32'h3f800000, 5'h01},   // below half
   {32'h3f800000, 32'h30800000, op_sub, 3'd0, 32'h3f800000, 5'h01},   // shift past all
   {32'h3f800000, 32'h30800000, op_sub, 3'd1, 32'h3f7fffff, 5'h01},
   {32'hbf800001, 32'hb3800000, op_add, 3'd0, 32'hbf800002, 5'h01},   // negative tie
   {32'hbf800001, 32'hb3800000, op_add, 3'd1, 32'hbf800001, 5'h01},
   {32'h3f800001, 32'h33800000, op_add, 3'd2, 32'h3f800002, 5'h01},   // rdn code acts rne
   {32'h3f800001, 32'h3fc00000, op_mul, 3'd0, 32'h3fc00002, 5'h01},   // product tie
   {32'h3f800001, 32'h3fc00000, op_mul, 3'd1, 32'h3fc00001, 5'h01},
   {32'h3fc00001, 32'h3fc00001, op_mul, 3'd0, 32'h40100002, 5'h01},   // product above half
   {32'h3fc00001, 32'h3fc00001, op_mul, 3'd1, 32'h40100001, 5'h01},
   // products
   {32'h40000000, 32'h40400000, op_mul, 3'd0, 32'h40c00000, 5'h00},   // 2 * 3
   {32'hc0000000, 32'h40400000, op_mul, 3'd0, 32'hc0c00000, 5'h00},   // -2 * 3
   {32'h71800000, 32'h71800000, op_mul, 3'd0, 32'h7f800000, 5'h05},   // 2^200, inf
   {32'h71800000, 32'h71800000, op_mul, 3'd1, 32'h7f7fffff, 5'h05},   // max finite
   {32'hf1800000, 32'h71800000, op_mul, 3'd0, 32'hff800000, 5'h05},
   {32'hf1800000, 32'h71800000, op_mul, 3'd1, 32'hff7fffff, 5'h05},
   {32'h0d800000, 32'h0d800000, op_mul, 3'd0, 32'h00000000, 5'h03},   // 2^-200 flushes
   {32'h8d800000, 32'h0d800000, op_mul, 3'd0, 32'h80000000, 5'h03},
   {32'h3f800000, 32'h80000000, op_mul, 3'd0, 32'h80000000, 5'h00},   // 1 * -0
   {32'h00000001, 32'h3f800000, op_mul, 3'd0, 32'h00000000, 5'h00},
   // special operands
   {32'h7fc00001, 32'h3f800000, op_add, 3'd0, 32'h7fc00000, 5'h10},   // qnan in
   {32'h7f800001, 32'h3f800000, op_mul, 3'd0, 32'h7fc00000, 5'h10},   // snan in
   {32'h7f800000, 32'h7f800000, op_sub, 3'd0, 32'h7fc00000, 5'h10},   // inf - inf
   {32'h00000000, 32'h7f800000, op_mul, 3'd0, 32'h7fc00000, 5'h10},   // 0 * inf
   {32'h3f800000, 32'h3f800000, 7'h01,  3'd0, 32'h7fc00000, 5'h10},   // unknown funct7
   {32'h7f800000, 32'h3f800000, op_add, 3'd0, 32'h7f800000, 5'h00},   // inf + 1
   {32'h3f800000, 32'h7f800000, op_sub, 3'd0, 32'hff800000, 5'h00}    // 1 - inf
};

`endif

// File: fpu_tb.sv
`timescale 1ns/1ps

module fpu_tb import fpu_pkg::*; ();

   localparam int res_depth    = 4;
   localparam int out_credits  = 2;
   localparam int drive_dly    = 2;     // ns after the rising edge
   localparam int wait_limit   = 100;   // cycles allowed per wait
   localparam int withhold_cyc = 20;

   logic             clk;
   logic             nrst;
   logic             op_valid;
   logic [31:0]      a;
   logic [31:0]      b;
   logic [6:0]       funct7;
   logic [2:0]       frm;
   logic             res_credit;
   logic             res_valid;
   logic [31:0]      result;
   logic [flag_nv:0] flags;
   logic             in_credit;

   int cyc        = 0;   // rising edges seen
   int sent       = 0;
   int in_credits = 0;   // upstream credits handed back
   int delivered  = 0;
   int returned   = 0;   // res_credit pulses

   // expected side, issue order
   logic [31:0]      exp_res_q   [$];
   logic [flag_nv:0] exp_flags_q [$];
   int               accept_q    [$];   // cycle of the accepting edge
   // what came out of the DUT
   logic [31:0]      got_res_q   [$];
   logic [flag_nv:0] got_flags_q [$];
   int               got_cyc_q   [$];

   `include "fpu_tb_vectors.svh"

   fpu_top #(
      .RES_DEPTH   (res_depth),
      .OUT_CREDITS (out_credits)
   ) fpu_top_i (
      .clk        (clk),
      .nrst       (nrst),
      .op_valid   (op_valid),
      .a          (a),
      .b          (b),
      .funct7     (funct7),
      .frm        (frm),
      .res_credit (res_credit),
      .res_valid  (res_valid),
      .result     (result),
      .flags      (flags),
      .in_credit  (in_credit)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;   // 100 ns period

   always @(posedge clk)
      cyc <= cyc + 1;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_result(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_flags(input string name, input logic [flag_nv:0] got,
                              input logic [flag_nv:0] exp);
      if (got !== exp)
         abort_run($sformatf("Fail at %0d ns: %s = %b, expected %b", $time, name, got, exp));
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
         abort_run($sformatf("Fail at %0d ns: %s = %0d, expected %0d", $time, name, got, exp));
   endtask

   // mid-cycle sampling, outputs settled
   always @(negedge clk) begin
      if (nrst) begin
         if (in_credit !== res_valid)
            abort_run($sformatf("Fail at %0d ns: in_credit = %b, expected %b",
                                $time, in_credit, res_valid));
         // counts exclude this cycle's credit pulse
         if (res_valid && (delivered - returned >= out_credits))
            abort_run("res_valid raised while the FPU held no downstream credit");
         if (res_valid) begin
            got_res_q.push_back(result);
            got_flags_q.push_back(flags);
            got_cyc_q.push_back(cyc);
            delivered++;
         end
         if (in_credit)
            in_credits++;
         if (res_credit)
            returned++;
      end
   end

   // starts and ends a few ns after a rising edge
   task automatic send_op(input logic [31:0] op_a, input logic [31:0] op_b,
                          input logic [6:0] op_f7, input logic [2:0] op_frm,
                          input logic [31:0] exp_res, input logic [flag_nv:0] exp_fl);
      int waited;
      waited = 0;
      while (res_depth - sent + in_credits == 0) begin   // no upstream credit
         if (waited == wait_limit)
            abort_run("timeout: no upstream credit came back for the next operation");
         waited++;
         @(posedge clk);
         #drive_dly;
      end
      a        = op_a;
      b        = op_b;
      funct7   = op_f7;
      frm      = op_frm;
      op_valid = 1'b1;
      exp_res_q.push_back(exp_res);
      exp_flags_q.push_back(exp_fl);
      sent++;
      @(posedge clk);
      #drive_dly;
      op_valid = 1'b0;
      accept_q.push_back(cyc);
   endtask

   task automatic send_vec(input int idx);
      logic [110:0] v;
      v = vec_tab[idx];
      send_op(v[110:79], v[78:47], v[46:40], v[39:37], v[36:5], v[4:0]);
   endtask

   // takes the oldest delivered result, then hands back one credit
   task automatic recv_result(input int gap, input bit check_lat);
      int waited;
      int acc;
      int got_cyc;
      waited = 0;
      while (got_res_q.size() == 0) begin
         if (waited == wait_limit)
            abort_run("timeout: res_valid never came for an issued operation");
         waited++;
         @(posedge clk);
         #drive_dly;
      end
      check_result("result", got_res_q.pop_front(), exp_res_q.pop_front());
      check_flags("flags", got_flags_q.pop_front(), exp_flags_q.pop_front());
      acc     = accept_q.pop_front();
      got_cyc = got_cyc_q.pop_front();
      if (check_lat)
         check_count("res_valid latency", got_cyc - acc, 3);
      repeat (gap) begin
         @(posedge clk);
         #drive_dly;
      end
      res_credit = 1'b1;   // single cycle pulse
      @(posedge clk);
      #drive_dly;
      res_credit = 1'b0;
   endtask

   // one at a time, empty buffer and full credits
   task automatic run_vectors();
      for (int i = 0; i < n_vec; i++) begin
         send_vec(i);
         recv_result(0, 1'b1);
      end
   endtask

   task automatic run_burst();
      fork
         begin
            for (int i = 0; i < res_depth; i++)
               send_vec(16 + i);   // back to back, mixed add and mul
         end
         begin
            for (int i = 0; i < res_depth; i++)
               recv_result(0, 1'b1);
         end
      join
   endtask

   task automatic run_backpressure();
      int base;
      base = delivered;
      fork
         begin
            for (int i = 0; i < res_depth + 3; i++)
               send_vec(22 + i);
         end
         begin
            repeat (withhold_cyc) begin
               @(posedge clk);
               #drive_dly;
            end
            // consumer is full, rest sit in the buffer
            check_count("results sent without credit", delivered - base, out_credits);
            for (int i = 0; i < res_depth + 3; i++)
               recv_result($urandom_range(3, 0), 1'b0);
         end
      join
   endtask

   initial begin
      void'($urandom(32'h817b1c05));
      nrst       = 1'b0;
      op_valid   = 1'b0;
      a          = 32'd0;
      b          = 32'd0;
      funct7     = 7'd0;
      frm        = 3'd0;
      res_credit = 1'b0;
      repeat (4) @(posedge clk);
      #drive_dly;
      nrst = 1'b1;
      @(posedge clk);
      #drive_dly;
      if (res_valid !== 1'b0 || in_credit !== 1'b0)
         abort_run("res_valid or in_credit not low after reset");
      run_vectors();
      run_burst();
      run_backpressure();
      check_count("in_credit pulses", in_credits, sent);   // one per issued op
      $display("** PASS **");
      $finish;
   end

endmodule

// File: fpu.f
+incdir+.
fpu_pkg.sv
fpu_align.sv
fpu_stage1.sv
fpu_stage2.sv
fpu_round.sv
fpu_result_buf.sv
fpu_top.sv
fpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fpu testbench with Verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module fpu_tb \
   -f fpu.f -o fpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/fpu_sim > sim.log 2>&1
run_status=$?

if grep -qF '** FAIL **' sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "simulation stopped with status $run_status, see sim.log"
   exit 1
fi
echo "simulation passed"
exit 0
